/* files.f */
+incdir+hw
hw/pu_pkg.sv
hw/pu_bus_if.sv
hw/div_seq.sv
hw/pu_div.sv
hw/pu_dispatch.sv
hw/bus_collect.sv
hw/pu_div_array.sv
bench/pu_div_assertions.sv
bench/pu_div_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module pu_div_tb -o pu_div_sim

status=0
./obj_dir/pu_div_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* bench/pu_div_tb.sv */
`default_nettype none

`include "pu_cfg.svh"

module pu_div_tb
  import pu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 6;
  localparam int OPS_PER_TEST = 16;
  localparam int CYCLE_LIMIT = NUM_TESTS * OPS_PER_TEST * (`PU_DIV_LATENCY + 10) + 500;

  logic    clk;
  logic    rst;
  logic    cmd_valid;
  pu_cmd_u cmd;
  data_t   data_in;
  attr_t   attr_in;
  logic    res_valid;
  data_t   res_data;
  attr_t   res_attr;
  logic    bad_cmd;
  int      errors;
  int      checks;
  int      tests_done;
  int      cycles;

  pu_div_array pu_div_array_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_attr(input attr_t got, input attr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // reference model of the division rule.
  function automatic data_t exp_quot(input data_t n, input data_t d);
    return (d == '0) ? '1 : n / d;
  endfunction

  function automatic data_t exp_rem(input data_t n, input data_t d);
    return (d == '0) ? n : n % d;
  endfunction

  function automatic attr_t exp_attr(input data_t d, input logic inv);
    attr_t a;
    a = '0;
    a[`PU_INVALID_BIT] = (d == '0) || inv;
    return a;
  endfunction

  // called right after a falling edge, holds the command for one cycle.
  task automatic send_cmd(input pu_cmd_u c, input data_t d, input attr_t a);
    cmd_valid = 1'b1;
    cmd       = c;
    data_in   = d;
    attr_in   = a;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic load_op(input pu_idx_t idx, input logic sel, input data_t d, input attr_t a);
    pu_cmd_u c;
    c = '0;
    c.load.op  = PU_OP_LOAD;
    c.load.idx = idx;
    c.load.sel = sel;
    send_cmd(c, d, a);
  endtask

  task automatic fetch_op(input pu_idx_t idx, input logic res_sel,
                          output data_t d, output attr_t a);
    pu_cmd_u c;
    int      waited;
    c = '0;
    c.fetch.op      = PU_OP_FETCH;
    c.fetch.idx     = idx;
    c.fetch.res_sel = res_sel;
    waited = 0;
    send_cmd(c, '0, '0);
    while (!res_valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!res_valid) begin
      errors++;
      $display("no result came back for a fetch from unit %0d at %0t", idx, $time);
    end
    d = res_data;
    a = res_attr;
  endtask

  task automatic wait_div();
    repeat (`PU_DIV_LATENCY + 3) @(negedge clk); // fixed latency of the units.
  endtask

  task automatic check_unit(input pu_idx_t idx, input data_t n, input data_t d,
                            input logic inv, input string tag);
    data_t got;
    attr_t got_attr;
    fetch_op(idx, 1'b1, got, got_attr);
    check_data(got, exp_quot(n, d), {tag, " quotient"});
    check_attr(got_attr, exp_attr(d, inv), {tag, " quotient attr"});
    fetch_op(idx, 1'b0, got, got_attr);
    check_data(got, exp_rem(n, d), {tag, " remainder"});
    check_attr(got_attr, exp_attr(d, inv), {tag, " remainder attr"});
  endtask

  task automatic run_pair(input pu_idx_t idx, input data_t n, input data_t d,
                          input attr_t dattr, input string tag);
    load_op(idx, 1'b0, n, '0);
    load_op(idx, 1'b1, d, dattr);
    wait_div();
    check_unit(idx, n, d, dattr[`PU_INVALID_BIT], tag);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_done++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_random();
    int    err_start;
    data_t n;
    data_t d;
    err_start = errors;
    for (int k = 0; k < 4; k++) begin
      n = $urandom;
      d = $urandom >> ($urandom % 32); // spread the quotient sizes.
      if (d == '0) begin
        d = data_t'(1);
      end
      run_pair(2'd0, n, d, '0, $sformatf("random pair %0d", k));
    end
    finish_test("random pairs", err_start);
  endtask

  task automatic test_zero_div();
    int err_start;
    err_start = errors;
    run_pair(2'd0, $urandom, '0, '0, "zero divisor");
    finish_test("zero divisor", err_start);
  endtask

  task automatic test_invalid_attr();
    int err_start;
    err_start = errors;
    run_pair(2'd3, 32'd1000, 32'd7, 4'b1011, "invalid attr");
    finish_test("invalid divisor attribute", err_start);
  endtask

  task automatic test_parallel();
    int    err_start;
    data_t n_arr [`PU_COUNT];
    data_t d_arr [`PU_COUNT];
    err_start = errors;
    for (int i = 0; i < `PU_COUNT; i++) begin
      n_arr[i] = $urandom;
      d_arr[i] = ($urandom & 32'h0000_ffff) + 32'd1;
      load_op(pu_idx_t'(i), 1'b0, n_arr[i], '0);
      load_op(pu_idx_t'(i), 1'b1, d_arr[i], '0);
    end
    wait_div();
    for (int i = 0; i < `PU_COUNT; i++) begin
      check_unit(pu_idx_t'(i), n_arr[i], d_arr[i], 1'b0, $sformatf("unit %0d", i));
    end
    finish_test("parallel units", err_start);
  endtask

  task automatic test_reload();
    int err_start;
    err_start = errors;
    load_op(2'd1, 1'b0, 32'd1000000, '0);
    load_op(2'd1, 1'b1, 32'd37, '0);
    repeat (10) @(negedge clk);
    load_op(2'd1, 1'b0, 32'd987654321, '0); // lands in the middle of the division.
    wait_div();
    check_unit(2'd1, 32'd987654321, 32'd37, 1'b0, "reload");
    finish_test("reload during division", err_start);
  endtask

  task automatic test_bad_cmd();
    int      err_start;
    pu_cmd_u c;
    err_start = errors;
    run_pair(2'd2, 32'hdeadbeef, 32'd1234, '0, "bad command base");
    c = '0;
    c.load.op    = PU_OP_LOAD;
    c.load.idx   = 2'd2;
    c.load.sel   = 1'b0;
    c.load.spare = '1;
    send_cmd(c, 32'h0000_0001, '0);
    check_flag(bad_cmd, 1'b1, "bad_cmd pulse");
    @(negedge clk);
    check_flag(bad_cmd, 1'b0, "bad_cmd after pulse");
    // a write that slipped through would have restarted the division by now.
    wait_div();
    check_unit(2'd2, 32'hdeadbeef, 32'd1234, 1'b0, "after bad command");
    // a new divisor reruns the division on the kept numerator.
    load_op(2'd2, 1'b1, 32'd1234, '0);
    wait_div();
    check_unit(2'd2, 32'hdeadbeef, 32'd1234, 1'b0, "rerun after bad command");
    finish_test("bad command", err_start);
  endtask

  initial begin
    void'($urandom(28505));
    errors     = 0;
    checks     = 0;
    tests_done = 0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    data_in    = '0;
    attr_in    = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_random();
    test_zero_div();
    test_invalid_attr();
    test_parallel();
    test_reload();
    test_bad_cmd();
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/pu_div_assertions.sv */
`default_nettype none

`include "pu_cfg.svh"

module pu_div_assertions
  import pu_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 cmd_valid,
  input pu_cmd_u              cmd,
  input logic                 res_valid,
  input logic                 bad_cmd,
  input logic [`PU_COUNT-1:0] wr_vec
);
  timeunit 1ns;
  timeprecision 100ps;

  logic fetch_ok;

  // a fetch only counts with its spare bits clear.
  assign fetch_ok = cmd_valid && (cmd.fetch.op == PU_OP_FETCH) && (cmd.fetch.spare == '0);

  a_res_after_fetch: assert property (@(posedge clk) disable iff (rst)
    fetch_ok |-> ##2 res_valid)
    else $error("res_valid missing two cycles after a fetch");

  a_res_from_fetch: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> $past(fetch_ok, 2))
    else $error("res_valid without a fetch two cycles before");

  a_res_low_after_reset: assert property (@(posedge clk)
    $past(rst) |-> !res_valid)
    else $error("res_valid high right after reset");

  // a command with spare bits set is flagged on the next cycle and writes no unit.
  a_bad_not_with_wr: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && (cmd.load.spare != '0)) |=> (bad_cmd && !(|wr_vec)))
    else $error("bad command not flagged or written to a unit");

endmodule

bind pu_div_array pu_div_assertions pu_div_assertions_i (
  .clk       (clk),
  .rst       (rst),
  .cmd_valid (cmd_valid),
  .cmd       (cmd),
  .res_valid (res_valid),
  .bad_cmd   (bad_cmd),
  .wr_vec    (pu_dispatch_i.wr_q)
);

`default_nettype wire

/* hw/pu_div_array.sv */
`default_nettype none

`include "pu_cfg.svh"

module pu_div_array
  import pu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    cmd_valid,
  input  pu_cmd_u cmd,
  input  data_t   data_in,
  input  attr_t   attr_in,
  output logic    res_valid,
  output data_t   res_data,
  output attr_t   res_attr,
  output logic    bad_cmd
);

  // one bus per unit between the dispatcher, the unit and the collector.
  pu_bus_if bus [`PU_COUNT] ();

  pu_dispatch pu_dispatch_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .data_in   (data_in),
    .attr_in   (attr_in),
    .bad_cmd   (bad_cmd),
    .bus       (bus)
  );

  for (genvar g = 0; g < `PU_COUNT; g++) begin : g_unit
    pu_div pu_div_i (
      .clk (clk),
      .rst (rst),
      .bus (bus[g])
    );
  end

  bus_collect bus_collect_i (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_attr  (res_attr)
  );

endmodule

`default_nettype wire

/* hw/bus_collect.sv */
`default_nettype none

`include "pu_cfg.svh"

module bus_collect
  import pu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  pu_bus_if.collect bus [`PU_COUNT],
  output logic  res_valid,
  output data_t res_data,
  output attr_t res_attr
);

  logic [`PU_COUNT-1:0] oe_vec;
  data_t                data_vec [`PU_COUNT];
  attr_t                attr_vec [`PU_COUNT];
  data_t                data_or;
  attr_t                attr_or;

  for (genvar g = 0; g < `PU_COUNT; g++) begin : g_tap
    assign oe_vec[g]   = bus[g].oe;
    assign data_vec[g] = bus[g].data_out;
    assign attr_vec[g] = bus[g].attr_out;
  end

  // idle units drive zero, so a plain OR gives the fetched word.
  always_comb begin
    data_or = '0;
    attr_or = '0;
    for (int i = 0; i < `PU_COUNT; i++) begin
      data_or = data_or | data_vec[i];
      attr_or = attr_or | attr_vec[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= |oe_vec;
    end
  end

  always_ff @(posedge clk) begin
    if (|oe_vec) begin
      res_data <= data_or; // held until the next fetch.
      res_attr <= attr_or;
    end
  end

endmodule

`default_nettype wire

/* hw/pu_dispatch.sv */
`default_nettype none

`include "pu_cfg.svh"

module pu_dispatch
  import pu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    cmd_valid,
  input  pu_cmd_u cmd,
  input  data_t   data_in,
  input  attr_t   attr_in,
  output logic    bad_cmd,
  pu_bus_if.dispatch bus [`PU_COUNT]
);

  logic                 is_fetch;
  logic                 spare_bad;
  logic                 accept;
  pu_idx_t              idx;
  logic [`PU_COUNT-1:0] hit;
  logic [`PU_COUNT-1:0] wr_q;
  logic [`PU_COUNT-1:0] oe_q;
  logic                 sel_q;
  logic                 res_sel_q;
  data_t                data_q;
  attr_t                attr_q;

  // the opcode bit sits at the same place in both views of the word.
  always_comb begin
    is_fetch = (cmd.load.op == PU_OP_FETCH);
    if (is_fetch) begin
      idx       = cmd.fetch.idx;
      spare_bad = |cmd.fetch.spare;
    end else begin
      idx       = cmd.load.idx;
      spare_bad = |cmd.load.spare;
    end
    accept = cmd_valid && !spare_bad; // a bad command is dropped.
    hit = '0;
    hit[idx] = accept;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q    <= '0;
      oe_q    <= '0;
      bad_cmd <= 1'b0;
    end else begin
      wr_q    <= is_fetch ? '0 : hit;
      oe_q    <= is_fetch ? hit : '0;
      bad_cmd <= cmd_valid && spare_bad;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !is_fetch) begin
      sel_q  <= cmd.load.sel;
      data_q <= data_in;
      attr_q <= attr_in;
    end
    if (accept && is_fetch) begin
      res_sel_q <= cmd.fetch.res_sel;
    end
  end

  // selects and operand are broadcast, and only the strobes are per unit.
  for (genvar g = 0; g < `PU_COUNT; g++) begin : g_bus
    assign bus[g].wr         = wr_q[g];
    assign bus[g].oe         = oe_q[g];
    assign bus[g].sel        = sel_q;
    assign bus[g].res_select = res_sel_q;
    assign bus[g].data_in    = data_q;
    assign bus[g].attr_in    = attr_q;
  end

endmodule

`default_nettype wire

/* hw/pu_div.sv */
`default_nettype none

`include "pu_cfg.svh"

module pu_div
  import pu_pkg::*;
(
  input logic  clk,
  input logic  rst,
  pu_bus_if.pu bus
);

  localparam int CNT_W = $clog2(`PU_DIV_LATENCY + 1);

  data_t            numer_q;
  data_t            denom_q;
  logic             denom_inv_q;
  data_t            numer_in;
  data_t            denom_in;
  data_t            quotient;
  data_t            remain;
  logic             div_done;
  logic [CNT_W-1:0] lat_cnt;
  data_t            quo_r;
  data_t            rem_r;
  logic             inv_r;
  attr_t            attr_res;

  always_ff @(posedge clk) begin
    if (bus.wr) begin
      if (bus.sel) begin
        denom_q <= bus.data_in;
      end else begin
        numer_q <= bus.data_in;
      end
    end
  end

  // the invalid attribute belongs to the denominator only.
  always_ff @(posedge clk) begin
    if (rst) begin
      denom_inv_q <= 1'b0;
    end else if (bus.wr && bus.sel) begin
      denom_inv_q <= bus.attr_in[`PU_INVALID_BIT];
    end
  end

  // the divider restarts on the same edge that captures the operand,
  // so the word being written is passed around its register.
  assign numer_in = (bus.wr && !bus.sel) ? bus.data_in : numer_q;
  assign denom_in = (bus.wr && bus.sel) ? bus.data_in : denom_q;

  div_seq div_seq_i (
    .clk      (clk),
    .rst      (rst),
    .start    (bus.wr),
    .numer    (numer_in),
    .denom    (denom_in),
    .quotient (quotient),
    .remain   (remain),
    .done     (div_done)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      lat_cnt <= '0;
    end else if (bus.wr) begin
      lat_cnt <= CNT_W'(`PU_DIV_LATENCY);
    end else if (lat_cnt != '0) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // a result is only taken once the full latency has run since the last write.
  always_ff @(posedge clk) begin
    if (rst) begin
      quo_r <= '0;
      rem_r <= '0;
      inv_r <= 1'b0;
    end else if (div_done && lat_cnt == '0) begin
      quo_r <= quotient;
      rem_r <= remain;
      inv_r <= (denom_q == '0) || denom_inv_q;
    end
  end

  always_comb begin
    attr_res = '0;
    attr_res[`PU_INVALID_BIT] = inv_r;
  end

  // outputs stay at zero unless this unit is fetched, which lets the collector OR them.
  assign bus.data_out = bus.oe ? (bus.res_select ? quo_r : rem_r) : '0;
  assign bus.attr_out = bus.oe ? attr_res : '0;

endmodule

`default_nettype wire

/* hw/div_seq.sv */
`default_nettype none

`include "pu_cfg.svh"

module div_seq
  import pu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  data_t numer,
  input  data_t denom,
  output data_t quotient,
  output data_t remain,
  output logic  done
);

  localparam int CNT_W = $clog2(`PU_DIV_LATENCY + 1);

  logic [CNT_W-1:0]        cnt;
  data_t                   quo_q;
  data_t                   rem_q;
  data_t                   den_q;
  logic [`PU_DATA_WIDTH:0] shifted;
  logic                    fits;

  // the numerator is shifted out of quo_q into the partial remainder, msb first,
  // and the quotient bits fill quo_q from the bottom.
  always_comb begin
    shifted = {rem_q, quo_q[`PU_DATA_WIDTH-1]};
    fits = (shifted >= {1'b0, den_q});
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        cnt <= CNT_W'(`PU_DIV_LATENCY); // a start during a run simply begins again.
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo_q <= numer;
      rem_q <= '0;
      den_q <= denom;
    end else if (cnt != '0) begin
      quo_q <= {quo_q[`PU_DATA_WIDTH-2:0], fits};
      // the difference always fits in one word once the subtraction is possible.
      if (fits) begin
        rem_q <= shifted[`PU_DATA_WIDTH-1:0] - den_q;
      end else begin
        rem_q <= shifted[`PU_DATA_WIDTH-1:0];
      end
    end
  end

  // with a zero divisor every step subtracts nothing, which leaves all ones
  // in the quotient and the numerator in the remainder.
  assign quotient = quo_q;
  assign remain   = rem_q;

endmodule

`default_nettype wire

/* hw/pu_bus_if.sv */
`default_nettype none

interface pu_bus_if
  import pu_pkg::*;
();

  logic  wr;         // load strobe, one cycle.
  logic  sel;        // operand select for wr.
  logic  res_select; // result select for oe.
  logic  oe;         // output enable, one cycle.
  data_t data_in;
  attr_t attr_in;
  data_t data_out;   // zero while oe is low.
  attr_t attr_out;

  modport dispatch (
    output wr,
    output sel,
    output res_select,
    output oe,
    output data_in,
    output attr_in
  );

  modport pu (
    input  wr,
    input  sel,
    input  res_select,
    input  oe,
    input  data_in,
    input  attr_in,
    output data_out,
    output attr_out
  );

  modport collect (
    input oe,
    input data_out,
    input attr_out
  );

endinterface

`default_nettype wire

/* hw/pu_pkg.sv */
`default_nettype none

`include "pu_cfg.svh"

package pu_pkg;

  typedef logic [`PU_DATA_WIDTH-1:0] data_t;
  typedef logic [`PU_ATTR_WIDTH-1:0] attr_t;
  typedef logic [$clog2(`PU_COUNT)-1:0] pu_idx_t;

  // the command word is 8 bits, the spare field takes what is left.
  localparam int PU_CMD_WIDTH = 8;
  localparam int PU_SPARE_WIDTH = PU_CMD_WIDTH - 2 - $bits(pu_idx_t);

  typedef enum logic {
    PU_OP_LOAD  = 1'b0,
    PU_OP_FETCH = 1'b1
  } pu_op_e;

  // sel is 0 for the numerator and 1 for the denominator.
  typedef struct packed {
    pu_op_e                    op;
    pu_idx_t                   idx;
    logic                      sel;
    logic [PU_SPARE_WIDTH-1:0] spare;
  } pu_load_t;

  // res_sel is 1 for the quotient and 0 for the remainder.
  typedef struct packed {
    pu_op_e                    op;
    pu_idx_t                   idx;
    logic                      res_sel;
    logic [PU_SPARE_WIDTH-1:0] spare;
  } pu_fetch_t;

  // both views share the opcode in the top bit.
  typedef union packed {
    pu_load_t  load;
    pu_fetch_t fetch;
  } pu_cmd_u;

endpackage

`default_nettype wire

/* hw/pu_cfg.svh */
`ifndef PU_CFG_SVH
`define PU_CFG_SVH

// width of one word on the shared data bus.
`define PU_DATA_WIDTH 32

// attribute field that travels next to each data word.
`define PU_ATTR_WIDTH 4

`define PU_INVALID_BIT 0 // position of the invalid flag inside the attribute.

// number of division units on the bus.
`define PU_COUNT 4

// one quotient bit per cycle, so the divider needs one cycle per data bit.
`define PU_DIV_LATENCY `PU_DATA_WIDTH

`endif
